// File: flist.f
+incdir+source
source/pbuf_pkg.sv
source/rx_scanner.sv
source/pbuf_writer.sv
source/pbuf_ram.sv
source/pbuf_top.sv
tests/pbuf_tb.sv

// File: Makefile
# Verilator build and run for the receive packet buffer testbench
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/10ps
TOP       := pbuf_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FLIST)) $(wildcard source/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# The run fails unless the testbench reports a pass
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: tests/pbuf_tb.sv
/*
 * Directed testbench for the receive packet buffer block. Sends frames
 * through the byte stream, reads back the packet buffer and both Rx MAC
 * banks, and checks badge words, data, bank status and the Gray pointer.
 * Build it with the file list and top module pbuf_tb.
 */
`timescale 1ns/10ps
`include "pbuf_params.svh"

module pbuf_tb
	import pbuf_pkg::*;
();

	localparam int BUF_WORDS = 2 ** `PBUF_AW;
	localparam int GAP = 8;
	localparam int N_FRAMES = 9;
	// Bytes of every frame the tests send
	localparam int TOTAL_BYTES = 100 + 40 + 80 + 1600 + 70 + 90 + 110 + 120 + 66;
	localparam int GRAY_CYCLES = 300;
	// Room for sending, a buffer scan per frame, read-back and the Gray stretch, twice over
	localparam int TIMEOUT_CYCLES = 2 * (TOTAL_BYTES + N_FRAMES * (GAP + 8)
		+ N_FRAMES * (BUF_WORDS + 1) + 3 * (TOTAL_BYTES + 5 * N_FRAMES) + GRAY_CYCLES + 64);

	logic       clk;
	logic       rst_n;
	logic       ce;
	logic [7:0] rx_data;
	logic       rx_frame;
	logic       rx_mac_hbank;
	logic       rx_mac_accept;
	pbuf_addr_t buf_raddr;
	mac_addr_t  mac_raddr;
	pbuf_word_t buf_rdata;
	logic [7:0] mac_rdata;
	logic [1:0] mac_buf_status;
	pbuf_addr_t gray_state;
	logic       badge_stb;

	// Two frame slots so an older frame can be rechecked after a newer one
	logic [7:0] frames [2][BUF_WORDS];
	int         lens [2];
	int         cycle_count = 0;

	pbuf_top dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			fail_now($sformatf("Timeout, the run did not finish within %0d clock cycles",
				cycle_count));
		end
	end

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic compare_value(input string what, input int idx, input int got, input int exp);
		assert (got == exp) else begin
			fail_now($sformatf("ERROR at %0t ns: %s [%0d] read %0h, expected %0h",
				$time, what, idx, got, exp));
		end
	endtask

	// Inputs change 10 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#10;
	endtask

	task automatic idle_cycles(input int n);
		ce = 1'b1;
		repeat (n) next_cycle();
	endtask

	// Runt, giant and broadcast bits from the frame as it was sent
	function automatic status_t expected_status(input int slot);
		logic bc;
		int   k;
		bc = lens[slot] >= 6;
		for (k = 0; k < 6 && k < lens[slot]; k++) begin
			if (frames[slot][k] != 8'hff) begin
				bc = 1'b0;
			end
		end
		return {5'b0, bc, lens[slot] > `GIANT_LEN, lens[slot] < `RUNT_LEN};
	endfunction

	// The length fields saturate at 2047
	function automatic pbuf_word_t badge_word(input int slot, input int idx);
		int len;
		len = (lens[slot] > 2047) ? 2047 : lens[slot];
		case (idx)
			0: return 9'h100;
			1: return 9'h180 | 9'(len % 128);
			2: return 9'(len / 128);
			3: return {1'b0, expected_status(slot)};
			default: return 9'h000;
		endcase
	endfunction

	function automatic pbuf_addr_t gray_to_bin(input pbuf_addr_t g);
		pbuf_addr_t b;
		int         i;
		b[`PBUF_AW-1] = g[`PBUF_AW-1];
		for (i = `PBUF_AW - 2; i >= 0; i--) begin
			b[i] = b[i+1] ^ g[i];
		end
		return b;
	endfunction

	task automatic send_frame(input int slot, input int len, input bit bcast);
		int k;
		int stb_cycles;
		lens[slot] = len;
		for (k = 0; k < len; k++) begin
			frames[slot][k] = (bcast && k < 6) ? 8'hff : 8'($urandom);
		end
		ce = 1'b1;
		rx_frame = 1'b1;
		for (k = 0; k < len; k++) begin
			rx_data = frames[slot][k];
			next_cycle();
			compare_value("badge_stb during data", k, int'(badge_stb), 0);
		end
		rx_frame = 1'b0;
		rx_data = 8'h00;
		// The badge is back-filled early in the gap and badge_stb marks each of its words
		stb_cycles = 0;
		repeat (GAP) begin
			next_cycle();
			stb_cycles += int'(badge_stb);
		end
		compare_value("badge_stb cycles", len, stb_cycles, 5);
		// The writer pauses during read-back because idle filler keeps running ahead
		ce = 1'b0;
	endtask

	task automatic read_buf(input int addr, output pbuf_word_t word);
		buf_raddr = pbuf_addr_t'(addr);
		next_cycle();
		word = buf_rdata;
	endtask

	task automatic read_mac(input logic bank, input int offset, output logic [7:0] value);
		mac_raddr = {bank, `MAC_AW'(offset)};
		next_cycle();
		value = mac_rdata;
	endtask

	// The origin holds the dummy word 100h and the length-high word follows it
	task automatic find_badge(input int slot, output int origin);
		pbuf_word_t prev;
		pbuf_word_t cur;
		int         a;
		origin = -1;
		read_buf(BUF_WORDS - 1, prev);
		for (a = 0; a < BUF_WORDS && origin < 0; a++) begin
			read_buf(a, cur);
			if (prev == badge_word(slot, 0) && cur == badge_word(slot, 1)) begin
				origin = (a + BUF_WORDS - 1) % BUF_WORDS;
			end
			prev = cur;
		end
		assert (origin >= 0) else begin
			fail_now($sformatf("No badge for the %0d-byte frame was found in the packet buffer",
				lens[slot]));
		end
	endtask

	task automatic check_buf_frame(input int slot);
		pbuf_word_t word;
		int         origin;
		int         i;
		find_badge(slot, origin);
		// The dummy and length-high words were matched by the search
		for (i = 2; i < 5; i++) begin
			read_buf((origin + i) % BUF_WORDS, word);
			compare_value("buffer badge word", i, int'(word), int'(badge_word(slot, i)));
		end
		// A frame longer than the buffer has wrapped over its own start
		if (lens[slot] + 5 <= BUF_WORDS) begin
			for (i = 0; i < lens[slot]; i++) begin
				read_buf((origin + 5 + i) % BUF_WORDS, word);
				compare_value("buffer data word", i, int'(word), int'({1'b0, frames[slot][i]}));
			end
		end
	endtask

	task automatic check_mac_frame(input int slot, input logic bank);
		logic [7:0] value;
		int         i;
		for (i = 0; i < 5; i++) begin
			read_mac(bank, i, value);
			compare_value("MAC badge byte", i, int'(value), int'(badge_word(slot, i) & 9'h0ff));
		end
		for (i = 0; i < lens[slot]; i++) begin
			read_mac(bank, 5 + i, value);
			compare_value("MAC data byte", i, int'(value), int'(frames[slot][i]));
		end
	endtask

	task automatic single_frame_to_buffer();
		send_frame(0, 100, 1'b0);
		check_buf_frame(0);
	endtask

	// Runt, broadcast and giant flags land in the status badge word
	task automatic status_flags_in_badge();
		send_frame(0, 40, 1'b0);
		check_buf_frame(0);
		send_frame(0, 80, 1'b1);
		check_buf_frame(0);
		send_frame(0, 1600, 1'b0);
		check_buf_frame(0);
	endtask

	// Host frees bank 0 and an accepted frame fills it
	task automatic capture_into_mac();
		rx_mac_hbank = 1'b1;
		rx_mac_accept = 1'b1;
		idle_cycles(4);
		compare_value("mac_buf_status before frame", 0, int'(mac_buf_status), 2);
		send_frame(0, 70, 1'b0);
		compare_value("mac_buf_status after frame", 0, int'(mac_buf_status), 3);
		check_mac_frame(0, 1'b0);
		check_buf_frame(0);
	endtask

	// While the host holds the bank a frame skips the MAC
	task automatic host_holds_bank();
		send_frame(1, 90, 1'b0);
		compare_value("mac_buf_status while held", 0, int'(mac_buf_status), 3);
		check_mac_frame(0, 1'b0);
		check_buf_frame(1);
		rx_mac_hbank = 1'b0;
		idle_cycles(4);
		send_frame(1, 110, 1'b0);
		compare_value("mac_buf_status after release", 0, int'(mac_buf_status), 0);
		check_mac_frame(1, 1'b1);
	endtask

	// A rejected frame keeps its bank so the next frame overwrites it
	task automatic rejected_frame_keeps_bank();
		rx_mac_hbank = 1'b1;
		rx_mac_accept = 1'b0;
		idle_cycles(4);
		send_frame(0, 120, 1'b0);
		compare_value("mac_buf_status after reject", 0, int'(mac_buf_status), 2);
		check_mac_frame(0, 1'b0);
		rx_mac_accept = 1'b1;
		send_frame(1, 66, 1'b0);
		compare_value("mac_buf_status after accept", 0, int'(mac_buf_status), 3);
		check_mac_frame(1, 1'b0);
		check_buf_frame(1);
	endtask

	task automatic gray_pointer_steps();
		pbuf_addr_t prev_g;
		pbuf_addr_t cur_g;
		pbuf_addr_t step;
		int         moves;
		int         i;
		moves = 0;
		prev_g = gray_state;
		for (i = 0; i < GRAY_CYCLES; i++) begin
			ce = 1'($urandom);
			next_cycle();
			cur_g = gray_state;
			// The modular difference lets a wrap count as one step forward
			step = gray_to_bin(cur_g) - gray_to_bin(prev_g);
			assert ($countones(cur_g ^ prev_g) <= 1) else begin
				fail_now($sformatf("ERROR at %0t ns: gray_state went %0h to %0h in one step",
					$time, prev_g, cur_g));
			end
			compare_value("gray pointer step", i, int'(step <= pbuf_addr_t'(1)), 1);
			moves += int'(step);
			prev_g = cur_g;
		end
		assert (moves > 0) else begin
			fail_now("The Gray pointer never advanced while ce was toggling");
		end
		ce = 1'b1;
	endtask

	initial begin
		void'($urandom(32'h6765));
		rst_n = 1'b0;
		ce = 1'b1;
		rx_data = 8'h00;
		rx_frame = 1'b0;
		rx_mac_hbank = 1'b0;
		rx_mac_accept = 1'b0;
		buf_raddr = '0;
		mac_raddr = '0;
		repeat (16) @(posedge clk);
		#10;
		rst_n = 1'b1;
		idle_cycles(4);
		single_frame_to_buffer();
		status_flags_in_badge();
		capture_into_mac();
		host_holds_bank();
		rejected_frame_keeps_bank();
		gray_pointer_steps();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

// File: source/pbuf_top.sv
/*
 * Receive packet buffer block. Joins the scanner, the writer, the
 * packet buffer RAM and the Rx MAC RAM. The read ports stand in for
 * the downstream reader and the host.
 */
`timescale 1ns/10ps
`include "pbuf_params.svh"

module pbuf_top
	import pbuf_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       ce,
	input  logic [7:0] rx_data,
	input  logic       rx_frame,
	input  logic       rx_mac_hbank,
	input  logic       rx_mac_accept,
	input  pbuf_addr_t buf_raddr,
	input  mac_addr_t  mac_raddr,
	output pbuf_word_t buf_rdata,
	output logic [7:0] mac_rdata,
	output logic [1:0] mac_buf_status,
	output pbuf_addr_t gray_state,
	output logic       badge_stb
);

	// Scanner to writer
	logic [7:0] data_in;
	logic       data_s;
	logic       data_f;
	pack_len_t  pack_len;
	status_t    status_vec;
	logic       status_valid;

	// Writer to the two memories
	logic       buf_we;
	pbuf_addr_t buf_addr;
	pbuf_word_t buf_wdata;
	logic       mac_we;
	mac_addr_t  mac_addr;
	logic [7:0] mac_wdata;

	rx_scanner scanner_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.ce           (ce),
		.rx_data      (rx_data),
		.rx_frame     (rx_frame),
		.data_in      (data_in),
		.data_s       (data_s),
		.data_f       (data_f),
		.pack_len     (pack_len),
		.status_vec   (status_vec),
		.status_valid (status_valid)
	);

	pbuf_writer writer_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.ce             (ce),
		.data_in        (data_in),
		.data_s         (data_s),
		.data_f         (data_f),
		.pack_len       (pack_len),
		.status_vec     (status_vec),
		.status_valid   (status_valid),
		.rx_mac_hbank   (rx_mac_hbank),
		.rx_mac_accept  (rx_mac_accept),
		.buf_we         (buf_we),
		.buf_addr       (buf_addr),
		.buf_wdata      (buf_wdata),
		.mac_we         (mac_we),
		.mac_addr       (mac_addr),
		.mac_wdata      (mac_wdata),
		.mac_buf_status (mac_buf_status),
		.gray_state     (gray_state),
		.badge_stb      (badge_stb)
	);

	pbuf_ram #(.addr_w(`PBUF_AW), .data_w(9)) buf_ram_i (
		.clk   (clk),
		.we    (buf_we),
		.waddr (buf_addr),
		.wdata (buf_wdata),
		.raddr (buf_raddr),
		.rdata (buf_rdata)
	);

	// Two banks of MAC_AW words, bank bit on top of the address
	pbuf_ram #(.addr_w(`MAC_AW + 1), .data_w(8)) mac_ram_i (
		.clk   (clk),
		.we    (mac_we),
		.waddr (mac_addr),
		.wdata (mac_wdata),
		.raddr (mac_raddr),
		.rdata (mac_rdata)
	);

endmodule

// File: source/pbuf_ram.sv
/*
 * Simple dual-port RAM, one write port and one registered read port
 * on a single clock. Used for both the packet buffer and the Rx MAC
 * memory; set the address and data widths per instance.
 */
`timescale 1ns/10ps

module pbuf_ram #(
	parameter int addr_w = 11,
	parameter int data_w = 9
) (
	input  logic              clk,
	input  logic              we,
	input  logic [addr_w-1:0] waddr,
	input  logic [data_w-1:0] wdata,
	input  logic [addr_w-1:0] raddr,
	output logic [data_w-1:0] rdata
);

	logic [data_w-1:0] mem [2**addr_w];

	// Start from a known image, the array itself has no reset
	initial begin
		for (int i = 0; i < 2**addr_w; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// Read data follows the address by one clock
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

endmodule

// File: source/pbuf_writer.sv
/*
 * Packet buffer writer. Streams frame data into the circular 9-bit
 * buffer five words past the frame origin, then goes back and fills
 * in the five-word badge once the scanner has the length and status.
 * The same words feed a double-banked Rx MAC memory, and the write
 * pointer is published in Gray code for a reader in another domain.
 */
`timescale 1ns/10ps
`include "pbuf_params.svh"

module pbuf_writer
	import pbuf_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       ce,
	input  logic [7:0] data_in,
	input  logic       data_s,
	input  logic       data_f,
	input  pack_len_t  pack_len,
	input  status_t    status_vec,
	input  logic       status_valid,
	input  logic       rx_mac_hbank,
	input  logic       rx_mac_accept,
	output logic       buf_we,
	output pbuf_addr_t buf_addr,
	output pbuf_word_t buf_wdata,
	output logic       mac_we,
	output mac_addr_t  mac_addr,
	output logic [7:0] mac_wdata,
	output logic [1:0] mac_buf_status,
	output pbuf_addr_t gray_state,
	output logic       badge_stb
);

	// Free-running pointer that advances on every ce cycle
	pbuf_addr_t   fp;
	// The first badge word goes to the pointer value captured at frame start
	pbuf_addr_t   origin;
	badge_phase_t phase;
	pbuf_word_t   pxd;
	status_t      status_r;
	logic         data_s_d;
	logic         trig;

	logic [`MAC_AW-1:0] mac_a0;
	logic               hbank_meta;
	logic               hbank_r;
	logic               mac_bank;
	logic               bank_free;
	logic               mac_save;
	logic               mac_stopping;
	logic               mac_queue;

	assign trig = data_s & ~data_s_d;

	// Status is held locally so the badge does not depend on scanner timing
	always_ff @(posedge clk) begin
		if (ce) begin
			if (status_valid) begin
				status_r <= status_vec;
			end
			unique case (phase)
				ph_dummy:    pxd <= 9'h100;
				ph_len_hi:   pxd <= {2'b11, pack_len[6:0]};
				ph_len_lo:   pxd <= {5'b0, pack_len[10:7]};
				ph_status:   pxd <= {1'b0, status_r};
				ph_reserved: pxd <= 9'h000;
				default:     pxd <= {1'b0, data_in};
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fp         <= '0;
			origin     <= '0;
			buf_addr   <= '0;
			phase      <= ph_pass;
			data_s_d   <= 1'b0;
			badge_stb  <= 1'b0;
			gray_state <= '0;
		end else if (ce) begin
			data_s_d <= data_s;
			if (trig) begin
				origin <= fp;
			end
			fp <= fp + 1'b1;
			// Badge starts on frame end and the counter parks in pass
			if (data_f) begin
				phase <= ph_dummy;
			end else if (phase != ph_pass) begin
				phase <= badge_phase_t'(phase + 3'd1);
			end
			// Data and idle filler run five ahead of the pointer
			// while badge words go back to the origin
			if (phase == ph_pass) begin
				buf_addr <= fp + pbuf_addr_t'(5);
			end else begin
				buf_addr <= origin + pbuf_addr_t'(phase);
			end
			badge_stb  <= phase != ph_pass;
			gray_state <= fp ^ (fp >> 1);
		end
	end

	assign buf_we    = ce;
	assign buf_wdata = pxd;

	// A bank is free when the host sits on the other one and holds new data when they match
	assign bank_free      = mac_bank != hbank_r;
	assign mac_buf_status = {hbank_r, mac_bank};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hbank_meta   <= 1'b0;
			hbank_r      <= 1'b0;
			mac_bank     <= 1'b0;
			mac_a0       <= '0;
			mac_save     <= 1'b0;
			mac_stopping <= 1'b0;
			mac_queue    <= 1'b0;
		end else if (ce) begin
			hbank_meta <= rx_mac_hbank;
			hbank_r    <= hbank_meta;
			// Data starts at offset 5 and the badge is put back at 0
			if (trig) begin
				mac_a0 <= `MAC_AW'(5);
			end else if (phase == ph_dummy) begin
				mac_a0 <= '0;
			end else begin
				mac_a0 <= mac_a0 + 1'b1;
			end
			mac_stopping <= phase == ph_reserved;
			// A frame is saved only if a bank was free when it started
			if (trig && bank_free) begin
				mac_save <= 1'b1;
			end else if (mac_stopping) begin
				mac_save <= 1'b0;
			end
			// Accept is sampled as the length-high word goes out
			if (mac_stopping) begin
				if (mac_queue) begin
					mac_bank <= ~mac_bank;
				end
				mac_queue <= 1'b0;
			end else if (phase == ph_len_hi && mac_save && rx_mac_accept) begin
				mac_queue <= 1'b1;
			end
		end
	end

	assign mac_we    = ce & mac_save;
	assign mac_addr  = {mac_bank, mac_a0};
	assign mac_wdata = pxd[7:0];

	a_phase_legal: assert property (
		@(posedge clk) disable iff (!rst_n)
		phase inside {ph_dummy, ph_len_hi, ph_len_lo, ph_status, ph_reserved, ph_pass}
	);

	// MAC writes only start into a bank the host has released
	a_mac_start_free: assert property (
		@(posedge clk) disable iff (!rst_n)
		$rose(mac_we) |-> bank_free
	);

endmodule

// File: source/rx_scanner.sv
/*
 * Receive byte stream scanner. Delays the stream by one ce cycle for
 * the writer and measures each frame on the way through. When the
 * frame strobe drops it publishes the length and the status byte
 * with a one-cycle frame-end pulse; the results hold until the next
 * frame ends.
 */
`timescale 1ns/10ps
`include "pbuf_params.svh"

module rx_scanner
	import pbuf_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      ce,
	input  logic [7:0] rx_data,
	input  logic      rx_frame,
	output logic [7:0] data_in,
	output logic      data_s,
	output logic      data_f,
	output pack_len_t pack_len,
	output status_t   status_vec,
	output logic      status_valid
);

	// Bytes seen so far in the current frame
	pack_len_t cnt;
	// Stays high while every leading byte has been FF
	logic      bcast;
	logic      frame_start;
	logic      frame_end;

	// Edges are found against the delayed strobe
	assign frame_start = rx_frame & ~data_s;
	assign frame_end   = data_s & ~rx_frame;

	// Data path, no reset needed
	always_ff @(posedge clk) begin
		if (ce) begin
			data_in <= rx_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			data_s       <= 1'b0;
			data_f       <= 1'b0;
			status_valid <= 1'b0;
			cnt          <= '0;
			bcast        <= 1'b0;
			pack_len     <= '0;
			status_vec   <= '0;
		end else if (ce) begin
			data_s       <= rx_frame;
			data_f       <= frame_end;
			status_valid <= frame_end;
			if (frame_start) begin
				cnt   <= pack_len_t'(1);
				bcast <= rx_data == 8'hff;
			end else if (rx_frame) begin
				// Count saturates so giants still report something sane
				if (cnt != '1) begin
					cnt <= cnt + 1'b1;
				end
				// Only the destination address decides broadcast
				if (cnt < pack_len_t'(6) && rx_data != 8'hff) begin
					bcast <= 1'b0;
				end
			end
			if (frame_end) begin
				pack_len   <= cnt;
				// A frame too short for a full address is never broadcast
				status_vec <= {5'b0,
					bcast & (cnt >= pack_len_t'(6)),
					cnt > pack_len_t'(`GIANT_LEN),
					cnt < pack_len_t'(`RUNT_LEN)};
			end
		end
	end

	// Frame end is a single ce-cycle pulse, the writer restarts its badge on it
	a_data_f_single: assert property (
		@(posedge clk) disable iff (!rst_n)
		(ce && data_f) |=> !data_f
	);

endmodule

// File: source/pbuf_pkg.sv
/*
 * Types for the receive packet buffer path. Import this in any
 * module that carries buffer words, addresses, lengths or status.
 * The widths come from the params header.
 */
`include "pbuf_params.svh"

package pbuf_pkg;

	// Bit 8 marks start of frame, bits 7:0 carry the byte
	typedef logic [8:0] pbuf_word_t;

	typedef logic [`PBUF_AW-1:0] pbuf_addr_t;

	// Top bit selects the MAC bank
	typedef logic [`MAC_AW:0] mac_addr_t;

	// Frame length in bytes, saturates at 2047
	typedef logic [10:0] pack_len_t;

	// Bit 0 runt, bit 1 giant, bit 2 broadcast, rest zero
	typedef logic [7:0] status_t;

	// Badge word being formed, pass lets data through
	typedef enum logic [2:0] {
		ph_dummy    = 3'd0,
		ph_len_hi   = 3'd1,
		ph_len_lo   = 3'd2,
		ph_status   = 3'd3,
		ph_reserved = 3'd4,
		ph_pass     = 3'd5
	} badge_phase_t;

endpackage

// File: source/pbuf_params.svh
/*
 * Size and limit macros shared by the packet buffer writer and its
 * testbench. Include this wherever a buffer width or a frame limit is
 * needed; the package pulls it in for its address types.
 */
`ifndef PBUF_PARAMS_SVH
`define PBUF_PARAMS_SVH

// Packet buffer address width, 11 in hardware and usable down to 8
`define PBUF_AW 11

// Address width inside one Rx MAC bank, the bank bit sits above it
`define MAC_AW 11

// Frames shorter than this are flagged as runts
`define RUNT_LEN 64

// Frames longer than this are flagged as giants
`define GIANT_LEN 1518

`endif
